// ==== design/rename_defines.svh ====
/*
 * widths and sizes for the rename block, included by the package and every module
 */

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 96

// tag widths
`define ARCH_W 5
`define PHYS_W 7

`define CDB_WIDTH 4 // completion broadcast lanes

// tags not held by the map at reset all start out free
`define FREE_DEPTH (`PHYS_REGS - `ARCH_REGS)
`define COUNT_W 7   // must hold FREE_DEPTH itself

`endif

// ==== design/rename_pkg.sv ====
/*
 * vector types shared by the rename RTL and its testbench
 */

`include "rename_defines.svh"

package rename_pkg;

	// architectural register number
	typedef logic [`ARCH_W-1:0] arch_reg_t;

	// physical register tag
	typedef logic [`PHYS_W-1:0] phys_reg_t;

	// free list occupancy, 0 .. FREE_DEPTH
	typedef logic [`COUNT_W-1:0] free_count_t;

	// instructions in a dispatch or retire group, 0 .. 2
	typedef logic [1:0] group_count_t;

endpackage

// ==== design/free_list.sv ====
/*
 * circular queue of free physical tags, grants two per cycle from the head
 * and takes two retired tags per cycle at the tail
 */

`timescale 1ns/1ps

`include "rename_defines.svh"

module free_list import rename_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  group_count_t dispatch_count,
	input  logic         dest_a_valid,
	input  logic         dest_b_valid,
	input  group_count_t retire_count,
	input  phys_reg_t    retire_tag0,
	input  phys_reg_t    retire_tag1,
	output phys_reg_t    tag_a,
	output phys_reg_t    tag_b,
	output logic         alloc_a,
	output logic         alloc_b,
	output free_count_t  free_count
);

	localparam int PTR_W = $clog2(`FREE_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t; // depth is a power of two, pointers wrap by themselves

	phys_reg_t   queue [`FREE_DEPTH];
	ptr_t        head;
	ptr_t        tail;
	free_count_t count;

	ptr_t         head_plus1;
	ptr_t         tail_plus1;
	group_count_t pop_count;
	group_count_t push_count;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// grant
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign alloc_a = (dispatch_count != 2'd0) && dest_a_valid;
	assign alloc_b = (dispatch_count == 2'd2) && dest_b_valid;

	assign head_plus1 = head + ptr_t'(1);
	assign tail_plus1 = tail + ptr_t'(1);

	// slot b moves up to the head when slot a takes nothing
	assign tag_a = queue[head];
	assign tag_b = alloc_a ? queue[head_plus1] : queue[head];

	assign pop_count  = {1'b0, alloc_a} + {1'b0, alloc_b};
	assign push_count = retire_count[1] ? 2'd2 : retire_count; // 3 is not a legal group

	assign free_count = count;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// queue state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `FREE_DEPTH; i++) begin
				queue[i] <= phys_reg_t'(`ARCH_REGS + i); // tags 32..95, head first
			end
			head  <= '0;
			tail  <= '0; // full, so tail has wrapped onto head
			count <= free_count_t'(`FREE_DEPTH);
		end else begin
			if (push_count != 2'd0)
				queue[tail] <= retire_tag0;
			if (push_count == 2'd2)
				queue[tail_plus1] <= retire_tag1;

			head  <= head + ptr_t'(pop_count);
			tail  <= tail + ptr_t'(push_count);
			count <= count - free_count_t'(pop_count) + free_count_t'(push_count);
		end
	end

	// dispatch may not take more tags than free_count showed it
	a_no_overdraw: assert property (
		@(posedge clock) disable iff (reset)
		pop_count <= count
	) else $error("free_list: %0d tags allocated with %0d free", pop_count, count);

	// retired tags must fit without counting this cycle's pops
	a_no_overflow: assert property (
		@(posedge clock) disable iff (reset)
		(count + push_count) <= `FREE_DEPTH
	) else $error("free_list: retire of %0d overflows count %0d", push_count, count);

endmodule

// ==== design/map_table.sv ====
/*
 * architectural to physical map with ready bits; looks up told and source tags
 * in the same cycle, bypasses slot a's new tag to slot b, wakes up on completion
 */

`timescale 1ns/1ps

`include "rename_defines.svh"

module map_table import rename_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,

	// rename group
	input  logic                  alloc_a,
	input  logic                  alloc_b,
	input  arch_reg_t             dest_a,
	input  arch_reg_t             dest_b,
	input  phys_reg_t             tag_a,
	input  phys_reg_t             tag_b,
	input  arch_reg_t             src_a1,
	input  arch_reg_t             src_a2,
	input  arch_reg_t             src_b1,
	input  arch_reg_t             src_b2,

	// completion broadcast
	input  logic [`CDB_WIDTH-1:0] cdb_valid,
	input  phys_reg_t             cdb_tag  [`CDB_WIDTH-1:0],
	input  arch_reg_t             cdb_arch [`CDB_WIDTH-1:0],

	output phys_reg_t             told_a,
	output phys_reg_t             told_b,
	output phys_reg_t             src_a1_tag,
	output phys_reg_t             src_a2_tag,
	output phys_reg_t             src_b1_tag,
	output phys_reg_t             src_b2_tag,
	output logic                  src_a1_ready,
	output logic                  src_a2_ready,
	output logic                  src_b1_ready,
	output logic                  src_b2_ready
);

	phys_reg_t              map_tag [`ARCH_REGS];
	logic [`ARCH_REGS-1:0]  ready_bit;
	logic [`ARCH_REGS-1:0]  ready_next;

	logic                   b1_hit;
	logic                   b2_hit;
	logic                   same_dest;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lookups
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// slot b sees slot a's rename before the map does
	assign b1_hit    = alloc_a && (src_b1 == dest_a);
	assign b2_hit    = alloc_a && (src_b2 == dest_a);
	assign same_dest = alloc_a && alloc_b && (dest_b == dest_a);

	assign told_a = map_tag[dest_a];
	assign told_b = same_dest ? tag_a : map_tag[dest_b];

	assign src_a1_tag   = map_tag[src_a1];
	assign src_a1_ready = ready_bit[src_a1];
	assign src_a2_tag   = map_tag[src_a2];
	assign src_a2_ready = ready_bit[src_a2];

	assign src_b1_tag   = b1_hit ? tag_a : map_tag[src_b1];
	assign src_b1_ready = b1_hit ? 1'b0  : ready_bit[src_b1]; // producer is still in flight
	assign src_b2_tag   = b2_hit ? tag_a : map_tag[src_b2];
	assign src_b2_ready = b2_hit ? 1'b0  : ready_bit[src_b2];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// wakeup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		ready_next = ready_bit;

		// a broadcast only counts if the register still maps to that tag
		for (int i = 0; i < `CDB_WIDTH; i++) begin
			if (cdb_valid[i] && (map_tag[cdb_arch[i]] == cdb_tag[i]))
				ready_next[cdb_arch[i]] = 1'b1;
		end

		// new producers clear last, so they beat a same-cycle broadcast
		if (alloc_a)
			ready_next[dest_a] = 1'b0;
		if (alloc_b)
			ready_next[dest_b] = 1'b0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// map and ready state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARCH_REGS; i++) begin
				map_tag[i] <= phys_reg_t'(i); // identity map
			end
			ready_bit <= '1;
		end else begin
			ready_bit <= ready_next;
			if (alloc_a)
				map_tag[dest_a] <= tag_a;
			if (alloc_b)
				map_tag[dest_b] <= tag_b; // younger slot wins on a shared dest
		end
	end

	// a valid lane must carry a real tag, or the compare above is meaningless
	for (genvar g = 0; g < `CDB_WIDTH; g++) begin : g_cdb_check
		a_cdb_tag_known: assert property (
			@(posedge clock) disable iff (reset)
			cdb_valid[g] |-> !$isunknown(cdb_tag[g])
		) else $error("map_table: cdb lane %0d valid with unknown tag", g);
	end

endmodule

// ==== design/rename_unit.sv ====
/*
 * rename block top, free list grants tags that the map table consumes in the
 * same cycle
 */

`timescale 1ns/1ps

`include "rename_defines.svh"

module rename_unit import rename_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,

	// dispatch group
	input  group_count_t          dispatch_count,
	input  logic                  dest_a_valid,
	input  arch_reg_t             dest_a,
	input  logic                  dest_b_valid,
	input  arch_reg_t             dest_b,
	input  arch_reg_t             src_a1,
	input  arch_reg_t             src_a2,
	input  arch_reg_t             src_b1,
	input  arch_reg_t             src_b2,

	// completion
	input  logic [`CDB_WIDTH-1:0] cdb_valid,
	input  phys_reg_t             cdb_tag  [`CDB_WIDTH-1:0],
	input  arch_reg_t             cdb_arch [`CDB_WIDTH-1:0],

	// retire
	input  group_count_t          retire_count,
	input  phys_reg_t             retire_tag0,
	input  phys_reg_t             retire_tag1,

	output phys_reg_t             tag_a,
	output phys_reg_t             tag_b,
	output free_count_t           free_count,
	output phys_reg_t             told_a,
	output phys_reg_t             told_b,
	output phys_reg_t             src_a1_tag,
	output phys_reg_t             src_a2_tag,
	output phys_reg_t             src_b1_tag,
	output phys_reg_t             src_b2_tag,
	output logic                  src_a1_ready,
	output logic                  src_a2_ready,
	output logic                  src_b1_ready,
	output logic                  src_b2_ready
);

	logic alloc_a; // slot actually takes a tag this cycle
	logic alloc_b;

	free_list u_free_list (
		.clock          (clock),
		.reset          (reset),
		.dispatch_count (dispatch_count),
		.dest_a_valid   (dest_a_valid),
		.dest_b_valid   (dest_b_valid),
		.retire_count   (retire_count),
		.retire_tag0    (retire_tag0),
		.retire_tag1    (retire_tag1),
		.tag_a          (tag_a),
		.tag_b          (tag_b),
		.alloc_a        (alloc_a),
		.alloc_b        (alloc_b),
		.free_count     (free_count)
	);

	map_table u_map_table (
		.clock        (clock),
		.reset        (reset),
		.alloc_a      (alloc_a),
		.alloc_b      (alloc_b),
		.dest_a       (dest_a),
		.dest_b       (dest_b),
		.tag_a        (tag_a),
		.tag_b        (tag_b),
		.src_a1       (src_a1),
		.src_a2       (src_a2),
		.src_b1       (src_b1),
		.src_b2       (src_b2),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_arch     (cdb_arch),
		.told_a       (told_a),
		.told_b       (told_b),
		.src_a1_tag   (src_a1_tag),
		.src_a2_tag   (src_a2_tag),
		.src_b1_tag   (src_b1_tag),
		.src_b2_tag   (src_b2_tag),
		.src_a1_ready (src_a1_ready),
		.src_a2_ready (src_a2_ready),
		.src_b1_ready (src_b1_ready),
		.src_b2_ready (src_b2_ready)
	);

endmodule

// ==== verif/rename_model.svh ====
/*
 * reference model of the rename block, included inside the testbench module
 */

`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

phys_reg_t m_map [`ARCH_REGS];
bit        m_ready [`ARCH_REGS];
phys_reg_t m_free [$];     // head first
phys_reg_t m_retire [$];   // told tags in dispatch order
phys_reg_t m_fly_tag [$];  // new tags not yet broadcast
arch_reg_t m_fly_arch [$];
bit [31:0] rng_state;

function automatic bit [31:0] xorshift();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

function automatic void reset_model();
	m_free.delete();
	m_retire.delete();
	m_fly_tag.delete();
	m_fly_arch.delete();
	for (int i = 0; i < `ARCH_REGS; i++) begin
		m_map[i]   = phys_reg_t'(i);
		m_ready[i] = 1'b1;
	end
	for (int i = `ARCH_REGS; i < `PHYS_REGS; i++)
		m_free.push_back(phys_reg_t'(i));
endfunction

// one clock edge of the block
function automatic void update_model(input bit take_a, input bit take_b,
		input arch_reg_t da, input arch_reg_t db, input group_count_t retired,
		input logic [`CDB_WIDTH-1:0] valid, input phys_reg_t tag [`CDB_WIDTH-1:0],
		input arch_reg_t arch [`CDB_WIDTH-1:0]);
	phys_reg_t new_tag;
	// broadcasts compare against the map before this group renames
	for (int i = 0; i < `CDB_WIDTH; i++) begin
		if (valid[i] && m_map[arch[i]] == tag[i])
			m_ready[arch[i]] = 1'b1;
	end
	if (take_a) begin
		new_tag = m_free.pop_front();
		m_retire.push_back(m_map[da]);
		m_ready[da] = 1'b0;
		m_map[da]   = new_tag;
		m_fly_tag.push_back(new_tag);
		m_fly_arch.push_back(da);
	end
	if (take_b) begin
		new_tag = m_free.pop_front();
		m_retire.push_back(m_map[db]); // already slot a's tag on a shared dest
		m_ready[db] = 1'b0;
		m_map[db]   = new_tag;
		m_fly_tag.push_back(new_tag);
		m_fly_arch.push_back(db);
	end
	for (int i = 0; i < retired; i++)
		m_free.push_back(m_retire.pop_front());
endfunction

`endif

// ==== verif/tb_rename.sv ====
/*
 * testbench for the rename block, random groups checked every cycle against
 * the model, one line per test and a closing count
 */

`timescale 1ns/1ps

`include "rename_defines.svh"

module tb_rename import rename_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int TEST_CYCLES  = 8 + 300 + 200 + 200 + 200 + 3 * 40;

	logic                  clock;
	logic                  reset;
	group_count_t          dispatch_count;
	group_count_t          retire_count;
	logic                  dest_a_valid, dest_b_valid;
	arch_reg_t             dest_a, dest_b, src_a1, src_a2, src_b1, src_b2;
	logic [`CDB_WIDTH-1:0] cdb_valid;
	phys_reg_t             cdb_tag  [`CDB_WIDTH-1:0];
	arch_reg_t             cdb_arch [`CDB_WIDTH-1:0];
	phys_reg_t             retire_tag0, retire_tag1, tag_a, tag_b, told_a, told_b;
	phys_reg_t             src_a1_tag, src_a2_tag, src_b1_tag, src_b2_tag;
	logic                  src_a1_ready, src_a2_ready, src_b1_ready, src_b2_ready;
	free_count_t           free_count;

	int errors;
	int test_errors;
	int tests_run;
	int guard;

	`include "rename_model.svh"

	rename_unit UUT (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		#(2 * (RESET_CYCLES + TEST_CYCLES) * 40);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got == expected) else begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, expected);
			test_errors++;
		end
	endtask

	// mode 1 stresses same-group hazards, mode 2 renames a register as it completes
	task automatic pick_inputs(input int disp, input int ret, input bit cdb_on, input int mode);
		bit [31:0] r;
		int        idx;
		r = xorshift();
		dispatch_count = (disp == 2 || mode != 0) ? 2'd2 : group_count_t'(r % 3);
		dest_a_valid   = (disp == 2 || mode != 0) ? 1'b1 : r[4];
		dest_b_valid   = (disp == 2 || mode != 0) ? 1'b1 : r[5];
		if (disp == 0)
			dispatch_count = 2'd0;
		if (m_free.size() < dispatch_count)
			dispatch_count = group_count_t'(m_free.size()); // never more than free_count
		dest_a = r[12:8];
		dest_b = r[17:13];
		r = xorshift();
		src_a1 = r[4:0];
		src_a2 = r[9:5];
		src_b1 = r[14:10];
		src_b2 = r[19:15];
		if (mode == 1) begin
			if (r[20]) dest_b = dest_a;
			if (r[21]) src_b1 = dest_a;
			if (r[22]) src_b2 = dest_a;
		end
		for (int i = 0; i < `CDB_WIDTH; i++) begin
			r = xorshift();
			cdb_valid[i] = 1'b0;
			cdb_tag[i]   = '0;
			cdb_arch[i]  = '0;
			if (cdb_on && r[0] && m_fly_tag.size() > 0) begin
				idx = (r >> 8) % m_fly_tag.size();
				cdb_valid[i] = 1'b1;
				cdb_tag[i]   = m_fly_tag[idx];
				cdb_arch[i]  = m_fly_arch[idx];
				m_fly_tag.delete(idx);
				m_fly_arch.delete(idx);
				if (mode == 2 && i == 0 && r[1])
					dest_a = cdb_arch[i];
			end else if (cdb_on && r[3:1] == 3'd0) begin
				cdb_valid[i] = 1'b1; // stale tag that the map usually rejects
				cdb_tag[i]   = r[14:8];
				cdb_arch[i]  = r[20:16];
			end
		end
		r = xorshift();
		retire_count = (ret == 2) ? 2'd2 : group_count_t'(r % 3);
		if (ret == 0)
			retire_count = 2'd0;
		if (m_retire.size() < retire_count)
			retire_count = group_count_t'(m_retire.size());
		retire_tag0 = (retire_count != 2'd0) ? m_retire[0] : '0;
		retire_tag1 = (retire_count == 2'd2) ? m_retire[1] : '0;
	endtask

	task automatic check_outputs();
		bit        take_a;
		bit        take_b;
		phys_reg_t exp_a;
		phys_reg_t exp_b;
		take_a = (dispatch_count != 2'd0) && dest_a_valid;
		take_b = (dispatch_count == 2'd2) && dest_b_valid;
		exp_a  = (m_free.size() > 0) ? m_free[0] : '0;
		exp_b  = (take_a && m_free.size() > 1) ? m_free[1] : exp_a;
		check_value("free_count", free_count, m_free.size());
		if (m_free.size() > 0)
			check_value("tag_a", tag_a, exp_a);
		if (m_free.size() > (take_a ? 1 : 0))
			check_value("tag_b", tag_b, exp_b);
		check_value("told_a", told_a, m_map[dest_a]);
		check_value("told_b", told_b,
				(take_a && take_b && dest_a == dest_b) ? exp_a : m_map[dest_b]);
		check_value("src_a1_tag", src_a1_tag, m_map[src_a1]);
		check_value("src_a2_tag", src_a2_tag, m_map[src_a2]);
		check_value("src_a1_ready", src_a1_ready, m_ready[src_a1]);
		check_value("src_a2_ready", src_a2_ready, m_ready[src_a2]);
		check_value("src_b1_tag", src_b1_tag,
				(take_a && src_b1 == dest_a) ? exp_a : m_map[src_b1]);
		check_value("src_b2_tag", src_b2_tag,
				(take_a && src_b2 == dest_a) ? exp_a : m_map[src_b2]);
		check_value("src_b1_ready", src_b1_ready,
				(take_a && src_b1 == dest_a) ? 1'b0 : m_ready[src_b1]);
		check_value("src_b2_ready", src_b2_ready,
				(take_a && src_b2 == dest_a) ? 1'b0 : m_ready[src_b2]);
		update_model(take_a, take_b, dest_a, dest_b, retire_count, cdb_valid, cdb_tag, cdb_arch);
	endtask

	// called 2 ns after an edge, returns 2 ns after the next one
	task automatic step_cycle(input int disp, input int ret, input bit cdb_on, input int mode);
		pick_inputs(disp, ret, cdb_on, mode);
		#37;
		check_outputs();
		@(posedge clock);
		#2;
	endtask

	task automatic finish_test(input string name);
		$display("test %-20s %0d errors", name, test_errors);
		errors += test_errors;
		tests_run++;
		test_errors = 0;
	endtask

	task automatic run_random(input string name, input int cycles, input int disp,
			input int ret, input bit cdb_on, input int mode);
		repeat (cycles) step_cycle(disp, ret, cdb_on, mode);
		finish_test(name);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		reset = 1'b1;
		{dispatch_count, retire_count, dest_a_valid, dest_b_valid} = '0;
		{dest_a, dest_b, src_a1, src_a2, src_b1, src_b2} = '0;
		{retire_tag0, retire_tag1, cdb_valid} = '0;
		for (int i = 0; i < `CDB_WIDTH; i++) begin
			cdb_tag[i]  = '0;
			cdb_arch[i] = '0;
		end
		errors      = 0;
		test_errors = 0;
		tests_run   = 0;
		rng_state   = 32'hab321700;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clock);
		#2 reset = 1'b0;

		repeat (7) step_cycle(0, 0, 1'b0, 0);
		step_cycle(2, 0, 1'b0, 0); // first full group takes 32 and 33
		finish_test("reset state");

		run_random("random dispatch", 300, 1, 1, 1'b1, 0);
		run_random("group hazards", 200, 1, 2, 1'b1, 1);
		run_random("completion wakeup", 200, 1, 2, 1'b1, 2);
		run_random("retire recycling", 200, 1, 2, 1'b1, 0);

		// drain with no retire, refill with dispatch held, then drain in refill order
		guard = 0;
		while (m_free.size() > 0 && guard < 40) begin
			step_cycle(2, 0, 1'b1, 0);
			guard++;
		end
		check_value("free_count", free_count, 0);
		guard = 0;
		while (m_retire.size() > 0 && guard < 40) begin
			step_cycle(0, 2, 1'b1, 0);
			guard++;
		end
		guard = 0;
		while (m_free.size() > 0 && guard < 40) begin
			step_cycle(2, 0, 1'b0, 0);
			guard++;
		end
		finish_test("exhaustion");

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+design
+incdir+verif
design/rename_pkg.sv
design/free_list.sv
design/map_table.sv
design/rename_unit.sv
verif/tb_rename.sv
